/* hdl/cache_op_req.sv */
`timescale 1ns/1ps

module cache_op_req
    import ibus_pkg::*;
(
    input  logic       clk,
    input  logic       i_rst_n,
    input  logic       i_flush,
    input  logic       i_valid,
    input  vaddr_t     i_addr,
    input  logic       i_fetch_finish,
    ibus_if.requester  bus,
    output icache_op_t o_icache_op,
    output logic       o_stall,
    output logic       o_busy,
    output logic       o_done,
    output logic       o_exc
);

    cop_state_t state;
    vaddr_t     op_addr;

    assign o_busy  = (state != C_IDLE);
    assign o_stall = o_busy;    // fetch is held for the whole operation

    assign o_icache_op[OP_ACTIVE] = o_busy;
    assign o_icache_op[OP_DATA]   = (state == C_WAIT_DATA);

    assign bus.req  = (state == C_REQ);
    assign bus.addr = op_addr;

    always_ff @(posedge clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            state  <= C_IDLE;
            o_done <= 1'b0;
            o_exc  <= 1'b0;
        end
        else
        begin
            o_done <= 1'b0;
            case (state)
                C_IDLE:
                    if (i_valid)
                        state <= C_DRAIN;
                C_DRAIN:
                    if (i_flush)
                    begin
                        state  <= C_IDLE;   // aborted before reaching the bus
                        o_done <= 1'b1;
                        o_exc  <= 1'b0;
                    end
                    else if (i_fetch_finish)
                        state <= C_REQ;
                C_REQ:
                    if (bus.flags[FLAG_REFILL])
                    begin
                        state  <= C_IDLE;
                        o_done <= 1'b1;
                        o_exc  <= 1'b1;
                    end
                    else if (bus.addr_ok)
                        state <= C_WAIT_DATA;
                C_WAIT_DATA:
                    if (bus.data_ok)
                    begin
                        state  <= C_IDLE;
                        o_done <= 1'b1;
                        o_exc  <= 1'b0;
                    end
                default:
                    state <= C_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if ((state == C_IDLE) && i_valid)
            op_addr <= i_addr;
    end

endmodule

/* hdl/fetch_req_gen.sv */
`timescale 1ns/1ps
`include "ibus_settings.svh"

module fetch_req_gen
    import ibus_pkg::*;
(
    input  logic     clk,
    input  logic     i_rst_n,
    input  logic     i_flush,
    input  vaddr_t   i_flush_pc,
    input  logic     i_stall,
    ibus_if.requester bus,
    output logic     o_finish,
    output logic     o_inst_valid,
    output inst_t    o_inst,
    output vaddr_t   o_inst_pc,
    output logic     o_exc
);

    fetch_state_t state;
    vaddr_t       pc;
    logic [1:0]   stale_cnt;    // responses still owed to flushed requests
    logic         take_data;
    logic         drop;
    logic         flush_lost;

    assign drop       = bus.data_ok && (stale_cnt != 2'd0);
    assign take_data  = (state == F_WAIT_DATA) && bus.data_ok && (stale_cnt == 2'd0);
    assign flush_lost = i_flush && (((state == F_REQ) && bus.addr_ok) ||
                                    ((state == F_WAIT_DATA) && !take_data));

    // idle under stall also counts as finished, otherwise a stopped fetch
    // would hold the cache op in its drain phase forever
    assign o_finish = take_data ||
                      (i_stall && (stale_cnt == 2'd0) &&
                       ((state == F_IDLE) || (state == F_EXC)));

    assign bus.req  = (state == F_REQ);
    assign bus.addr = pc;
    assign o_exc    = (state == F_EXC);

    always_ff @(posedge clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            state        <= F_IDLE;
            pc           <= `RESET_PC;
            stale_cnt    <= 2'd0;
            o_inst_valid <= 1'b0;
        end
        else
        begin
            o_inst_valid <= take_data && !i_flush;
            stale_cnt    <= stale_cnt + {1'b0, flush_lost} - {1'b0, drop};
            if (i_flush)
            begin
                state <= F_IDLE;
                pc    <= i_flush_pc;
            end
            else
            begin
                case (state)
                    F_IDLE:
                        if (!i_stall)
                            state <= F_REQ;
                    F_REQ:
                        if (bus.flags[FLAG_REFILL])
                            state <= F_EXC;     // no tlb, stop until flush
                        else if (bus.addr_ok)
                            state <= F_WAIT_DATA;
                    F_WAIT_DATA:
                        if (take_data)
                        begin
                            pc    <= pc + `ADDR_W'd4;
                            state <= i_stall ? F_IDLE : F_REQ;
                        end
                    default:
                        state <= F_EXC;
                endcase
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (take_data)
        begin
            o_inst    <= bus.rdata;
            o_inst_pc <= pc;
        end
    end

    a_addr_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
        bus.req && !bus.addr_ok && !i_flush && !bus.flags[FLAG_REFILL]
        |=> bus.req && $stable(bus.addr));

endmodule

/* hdl/fixed_map_tu.sv */
`timescale 1ns/1ps
`include "ibus_settings.svh"

module fixed_map_tu
    import ibus_pkg::*;
(
    input  logic      i_req,
    input  vaddr_t    i_vaddr,
    output tu_flags_t o_flags,
    output logic      o_mem_req,
    output paddr_t    o_mem_addr
);

    logic unmapped;

    // kseg0 and kseg1 translate by dropping the segment bits
    assign unmapped   = (i_vaddr >= `KSEG0_BASE) && (i_vaddr < `KSEG2_BASE);
    assign o_mem_addr = {3'b000, i_vaddr[`ADDR_W-4:0]};

    always_comb
    begin
        o_flags                = '0;
        o_flags[FLAG_MAPPED]   = !unmapped;
        o_flags[FLAG_REFILL]   = !unmapped;    // nothing to look up, always a miss
        o_flags[FLAG_INVALID]  = 1'b0;
        o_flags[FLAG_MODIFIED] = 1'b0;
    end

    assign o_mem_req = i_req && unmapped;

endmodule

/* hdl/ibus_if.sv */
`timescale 1ns/1ps

interface ibus_if
    import ibus_pkg::*;
();

    logic      req;
    vaddr_t    addr;
    logic      addr_ok;
    logic      data_ok;
    inst_t     rdata;
    tu_flags_t flags;   // translation result for addr, same cycle

    modport requester
    (
        output req,
        output addr,
        input  addr_ok,
        input  data_ok,
        input  rdata,
        input  flags
    );

    modport selector
    (
        input  req,
        input  addr,
        output addr_ok,
        output data_ok,
        output rdata,
        output flags
    );

endinterface

/* hdl/ibus_pkg.sv */
`include "ibus_settings.svh"

package ibus_pkg;

    typedef logic [`ADDR_W-1:0] vaddr_t;
    typedef logic [`ADDR_W-1:0] paddr_t;
    typedef logic [31:0]        inst_t;

    // bit 1 op active, bit 0 data responses go to the cop side
    typedef logic [1:0] icache_op_t;

    localparam int OP_ACTIVE = 1;
    localparam int OP_DATA   = 0;

    // {tlb_invalid, tlb_modified, tlb_refill, mapped}
    typedef logic [3:0] tu_flags_t;

    localparam int FLAG_INVALID  = 3;
    localparam int FLAG_MODIFIED = 2;
    localparam int FLAG_REFILL   = 1;
    localparam int FLAG_MAPPED   = 0;

    typedef enum logic [1:0]
    {
        F_IDLE,
        F_REQ,
        F_WAIT_DATA,
        F_EXC
    } fetch_state_t;

    typedef enum logic [1:0]
    {
        C_IDLE,
        C_DRAIN,
        C_REQ,
        C_WAIT_DATA
    } cop_state_t;

endpackage

/* hdl/ifetch_bus_top.sv */
`timescale 1ns/1ps

module ifetch_bus_top
    import ibus_pkg::*;
(
    input  logic   clk,
    input  logic   i_rst_n,
    input  logic   i_flush,
    input  vaddr_t i_flush_pc,
    input  logic   i_cop_valid,
    input  vaddr_t i_cop_addr,
    output logic   o_mem_req,
    output paddr_t o_mem_addr,
    input  logic   i_mem_addr_ok,
    input  logic   i_mem_data_ok,
    input  inst_t  i_mem_rdata,
    output logic   o_inst_valid,
    output inst_t  o_inst,
    output vaddr_t o_inst_pc,
    output logic   o_fetch_exc,
    output logic   o_cop_busy,
    output logic   o_cop_done,
    output logic   o_cop_exc
);

    ibus_if fetch_bus ();
    ibus_if cop_bus ();

    logic       fetch_stall;
    logic       fetch_finish;
    icache_op_t icache_op;
    logic       sel_req;
    vaddr_t     sel_vaddr;
    tu_flags_t  tu_flags;

    fetch_req_gen u_fetch
    (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_flush      (i_flush),
        .i_flush_pc   (i_flush_pc),
        .i_stall      (fetch_stall),
        .bus          (fetch_bus.requester),
        .o_finish     (fetch_finish),
        .o_inst_valid (o_inst_valid),
        .o_inst       (o_inst),
        .o_inst_pc    (o_inst_pc),
        .o_exc        (o_fetch_exc)
    );

    cache_op_req u_cop
    (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_flush        (i_flush),
        .i_valid        (i_cop_valid),
        .i_addr         (i_cop_addr),
        .i_fetch_finish (fetch_finish),
        .bus            (cop_bus.requester),
        .o_icache_op    (icache_op),
        .o_stall        (fetch_stall),
        .o_busy         (o_cop_busy),
        .o_done         (o_cop_done),
        .o_exc          (o_cop_exc)
    );

    inst_req_select u_sel
    (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_stall     (fetch_stall),
        .i_flush     (i_flush),
        .i_icache_op (icache_op),
        .i_finish_f  (fetch_finish),
        .fetch       (fetch_bus.selector),
        .cop         (cop_bus.selector),
        .o_req       (sel_req),
        .o_vaddr     (sel_vaddr),
        .i_flags     (tu_flags),
        .i_addr_ok   (i_mem_addr_ok),
        .i_data_ok   (i_mem_data_ok),
        .i_rdata     (i_mem_rdata)
    );

    fixed_map_tu u_tu
    (
        .i_req      (sel_req),
        .i_vaddr    (sel_vaddr),
        .o_flags    (tu_flags),
        .o_mem_req  (o_mem_req),
        .o_mem_addr (o_mem_addr)
    );

endmodule

/* hdl/inst_req_select.sv */
`timescale 1ns/1ps

module inst_req_select
    import ibus_pkg::*;
(
    input  logic       clk,
    input  logic       i_rst_n,
    input  logic       i_stall,
    input  logic       i_flush,
    input  icache_op_t i_icache_op,
    input  logic       i_finish_f,
    ibus_if.selector   fetch,
    ibus_if.selector   cop,
    output logic       o_req,
    output vaddr_t     o_vaddr,
    input  tu_flags_t  i_flags,
    input  logic       i_addr_ok,
    input  logic       i_data_ok,
    input  inst_t      i_rdata
);

    logic finish_his;       // fetch transaction drained during this op
    logic first_cycle;
    logic fetch_owns;
    logic cop_owns;

    always_ff @(posedge clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            finish_his  <= 1'b0;
            first_cycle <= 1'b1;
        end
        else if (i_flush || !i_stall)
        begin
            finish_his  <= 1'b0;
            first_cycle <= 1'b1;
        end
        else
        begin
            if (finish_his)
                first_cycle <= 1'b0;
            if (i_finish_f)
                finish_his <= 1'b1;
        end
    end

    // one idle cycle on the bus between the last fetch and the cop request
    assign fetch_owns = !i_icache_op[OP_ACTIVE] || !finish_his;
    assign cop_owns   = i_icache_op[OP_ACTIVE] && finish_his && !first_cycle;

    always_comb
    begin
        if (fetch_owns)
        begin
            o_req   = fetch.req;
            o_vaddr = fetch.addr;
        end
        else if (cop_owns)
        begin
            o_req   = cop.req;
            o_vaddr = cop.addr;
        end
        else
        begin
            o_req   = 1'b0;
            o_vaddr = cop.addr;
        end
    end

    assign fetch.addr_ok = fetch_owns && i_addr_ok;
    assign cop.addr_ok   = cop_owns && i_addr_ok;

    // data responses follow the op code, not the request owner
    assign fetch.data_ok = !i_icache_op[OP_DATA] && i_data_ok;
    assign cop.data_ok   = i_icache_op[OP_DATA] && i_data_ok;

    assign fetch.flags = fetch_owns ? i_flags : '0;
    assign cop.flags   = cop_owns ? i_flags : '0;

    assign fetch.rdata = i_rdata;
    assign cop.rdata   = i_rdata;

    a_addr_ok_one_side: assert property (@(posedge clk) disable iff (!i_rst_n)
        !(fetch.addr_ok && cop.addr_ok));

endmodule

/* include/ibus_settings.svh */
`ifndef IBUS_SETTINGS_SVH
`define IBUS_SETTINGS_SVH

// virtual and physical address width
`define ADDR_W      32

`define RESET_PC    32'hbfc0_0000   // boot vector in kseg1

// kseg0 and kseg1 lie in [KSEG0_BASE, KSEG2_BASE) and are unmapped
`define KSEG0_BASE  32'h8000_0000
`define KSEG2_BASE  32'hc000_0000

`endif

/* sim.f */
+incdir+include
hdl/ibus_pkg.sv
hdl/ibus_if.sv
hdl/fetch_req_gen.sv
hdl/cache_op_req.sv
hdl/inst_req_select.sv
hdl/fixed_map_tu.sv
hdl/ifetch_bus_top.sv
verification/tb_ifetch_bus.sv

/* verification/tb_ifetch_bus.sv */
`timescale 1ns/1ps
`include "ibus_settings.svh"

module tb_ifetch_bus
    import ibus_pkg::*;
();

    logic   clk = 1'b1;
    logic   i_rst_n = 1'b1;
    logic   i_flush;
    vaddr_t i_flush_pc;
    logic   i_cop_valid;
    vaddr_t i_cop_addr;
    logic   o_mem_req;
    paddr_t o_mem_addr;
    logic   i_mem_addr_ok = 1'b0;
    logic   i_mem_data_ok = 1'b0;
    inst_t  i_mem_rdata   = '0;
    logic   o_inst_valid;
    inst_t  o_inst;
    vaddr_t o_inst_pc;
    logic   o_fetch_exc;
    logic   o_cop_busy;
    logic   o_cop_done;
    logic   o_cop_exc;

    integer     seed = 32'h269d_c795;
    paddr_t     mem_q[$];           // accepted and data not yet returned
    logic [1:0] acc_dly  = 2'd0;
    logic [1:0] data_dly = 2'd0;
    paddr_t     acc_addr;
    vaddr_t     exp_pc;             // pc of the next delivered word
    vaddr_t     exp_req;            // next fetch address on the bus
    vaddr_t     cop_vaddr = '0;
    logic       valid_seen;
    logic       busy_prev;
    int         op_valids;          // fetch words delivered after the op started
    int         cop_acc;
    int         done_cnt;
    int         ops_cnt = 0;

    ifetch_bus_top UUT (.*);

    always #2 clk = ~clk;

    function automatic paddr_t phys_addr(input vaddr_t va);
        phys_addr = va;
        phys_addr[`ADDR_W-1 -: 3] = 3'b000;
    endfunction

    function automatic logic is_mapped(input vaddr_t va);
        is_mapped = (va[`ADDR_W-1 -: 2] != 2'b10);
    endfunction

    function automatic logic [1:0] rand_delay();
        rand_delay = {$random(seed)} % 3;
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1, "stopped at first error");
    endtask

    // memory model and bookkeeping on the falling edge
    always @(negedge clk)
    begin
        if (!i_rst_n)
        begin
            i_mem_addr_ok <= 1'b0;
            i_mem_data_ok <= 1'b0;
            mem_q.delete();
            acc_dly    <= rand_delay();
            data_dly   <= rand_delay();
            exp_pc     <= `RESET_PC;
            exp_req    <= `RESET_PC;
            valid_seen <= 1'b0;
            busy_prev  <= 1'b0;
            op_valids  <= 0;
            cop_acc    <= 0;
            done_cnt   <= 0;
        end
        else
        begin
            // data phase first so data_ok never shares a cycle with its addr_ok
            if (i_mem_data_ok)
            begin
                i_mem_data_ok <= 1'b0;
                data_dly      <= rand_delay();
            end
            else if (mem_q.size() != 0)
            begin
                if (data_dly == 2'd0)
                begin
                    i_mem_data_ok <= 1'b1;
                    i_mem_rdata   <= ~mem_q.pop_front();
                end
                else
                    data_dly <= data_dly - 2'd1;
            end
            if (i_mem_addr_ok)
            begin
                i_mem_addr_ok <= 1'b0;
                acc_dly       <= rand_delay();
            end
            else if (o_mem_req)
            begin
                if (acc_dly == 2'd0)
                begin
                    i_mem_addr_ok <= 1'b1;
                    acc_addr      <= o_mem_addr;
                    mem_q.push_back(o_mem_addr);
                end
                else
                    acc_dly <= acc_dly - 2'd1;
            end

            valid_seen <= o_inst_valid;
            busy_prev  <= o_cop_busy;
            if (i_flush)
            begin
                exp_pc  <= i_flush_pc;
                exp_req <= i_flush_pc;
            end
            else
            begin
                if (valid_seen)
                    exp_pc <= exp_pc + 4;
                if (i_mem_addr_ok && (acc_addr == phys_addr(exp_req)))
                    exp_req <= exp_req + 4;     // accept took place at the last edge
            end
            if (!o_cop_busy)
                op_valids <= 0;
            else if (o_inst_valid && busy_prev)
                op_valids <= op_valids + 1;
            if (!o_cop_busy && !o_cop_done)
                cop_acc <= 0;
            else if (i_mem_addr_ok && (acc_addr == phys_addr(cop_vaddr)))
                cop_acc <= cop_acc + 1;
            if (o_cop_done)
                done_cnt <= done_cnt + 1;
        end
    end

    a_reset_low: assert property (@(posedge clk) !i_rst_n |-> !o_mem_req && !o_inst_valid
        && !o_cop_busy && !o_cop_done && !o_cop_exc && !o_fetch_exc)
        else stop_on_error("outputs are not all low during reset");

    a_pc_seq: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_inst_valid |-> o_inst_pc == exp_pc)
        else stop_on_error($sformatf("error at %0t: o_inst_pc is %h, expected %h",
            $time, $sampled(o_inst_pc), $sampled(exp_pc)));

    a_inst_word: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_inst_valid |-> o_inst == ~phys_addr(exp_pc))
        else stop_on_error($sformatf("error at %0t: o_inst is %h, expected %h",
            $time, $sampled(o_inst), ~phys_addr($sampled(exp_pc))));

    a_mem_addr: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_mem_req |-> (o_mem_addr == phys_addr(exp_req) && !is_mapped(exp_req)) ||
        (o_cop_busy && o_mem_addr == phys_addr(cop_vaddr) && !is_mapped(cop_vaddr)))
        else stop_on_error($sformatf("error at %0t: o_mem_addr is %h, expected %h",
            $time, $sampled(o_mem_addr), phys_addr($sampled(exp_req))));

    a_busy_rise: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_cop_valid && !o_cop_busy |=> o_cop_busy)
        else stop_on_error("cache operation did not raise busy at the next edge");

    a_cop_drained: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_mem_req && o_cop_busy && o_mem_addr == phys_addr(cop_vaddr) |-> op_valids == 1)
        else stop_on_error("cache operation reached the bus before the fetch drained");

    a_fetch_held: assert property (@(posedge clk) disable iff (!i_rst_n) op_valids <= 1)
        else stop_on_error("fetch delivered a new word during a cache operation");

    a_done_once: assert property (@(posedge clk) disable iff (!i_rst_n) done_cnt <= ops_cnt)
        else stop_on_error("o_cop_done pulsed more often than operations were issued");

    a_cop_exc: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_cop_done |-> o_cop_exc == is_mapped(cop_vaddr))
        else stop_on_error($sformatf("error at %0t: o_cop_exc is %b, expected %b",
            $time, $sampled(o_cop_exc), is_mapped($sampled(cop_vaddr))));

    a_cop_access: assert property (@(posedge clk) disable iff (!i_rst_n)
        (cop_acc <= 1) && (!o_cop_done || (cop_acc == (is_mapped(cop_vaddr) ? 0 : 1))))
        else stop_on_error("wrong number of memory accesses for the cache operation");

    task automatic wait_valids(input int n);
        int seen;
        int cycles;
        seen   = 0;
        cycles = 0;
        while ((seen < n) && (cycles < 40 * n))
        begin
            @(negedge clk);
            cycles++;
            if (o_inst_valid)
                seen++;
        end
        if (seen < n)
            stop_on_error($sformatf("timeout, %0d of %0d fetch words delivered", seen, n));
    endtask

    task automatic run_cache_op(input vaddr_t addr);
        int cycles;
        cycles      = 0;
        i_cop_addr  <= addr;
        i_cop_valid <= 1'b1;
        cop_vaddr   <= addr;
        ops_cnt     <= ops_cnt + 1;
        @(negedge clk);
        i_cop_valid <= 1'b0;
        while (!o_cop_done && (cycles < 100))
        begin
            @(negedge clk);
            cycles++;
        end
        if (!o_cop_done)
            stop_on_error("timeout, cache operation never reported done");
    endtask

    task automatic flush_fetch(input vaddr_t pc);
        i_flush_pc <= pc;
        i_flush    <= 1'b1;
        @(negedge clk);
        i_flush    <= 1'b0;
    endtask

    task automatic wait_fetch_exc(input logic level);
        int cycles;
        cycles = 0;
        while ((o_fetch_exc !== level) && (cycles < 50))
        begin
            @(negedge clk);
            cycles++;
        end
        if (o_fetch_exc !== level)
            stop_on_error($sformatf("timeout, o_fetch_exc never reached %b", level));
    endtask

    initial
    begin
        i_flush     = 1'b0;
        i_flush_pc  = `RESET_PC;
        i_cop_valid = 1'b0;
        i_cop_addr  = '0;
        @(negedge clk);
        i_rst_n <= 1'b0;
        repeat (10) @(negedge clk);
        i_rst_n <= 1'b1;

        wait_valids(8);
        run_cache_op(32'h8000_2000);    // kseg0
        wait_valids(4);
        run_cache_op(32'h0000_3000);    // kuseg gives a refill without access
        wait_valids(4);
        run_cache_op(32'ha000_2040);    // kseg1
        wait_valids(4);

        flush_fetch(32'h0040_0000);
        wait_fetch_exc(1'b1);
        repeat (6) @(negedge clk);      // exc must hold with no bus traffic
        wait_fetch_exc(1'b1);
        flush_fetch(32'h8000_0400);
        wait_fetch_exc(1'b0);
        wait_valids(6);
        repeat (4) @(negedge clk);

        $display("No errors");
        $finish;
    end

endmodule
